/* Bender.yml */
package:
  name: multicycle_cpu

sources:
  - common/mipsPkg.sv
  - rtl/controlUnit.sv
  - rtl/pcUnit.sv
  - rtl/memoryPort.sv
  - rtl/registerFile.sv
  - rtl/aluUnit.sv
  - rtl/multicycleCpu.sv
  - target: test
    files:
      - testbench/cpuTb.sv

/* common/mipsPkg.sv */
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth = 16;
    localparam int jumpWidth = 26;

    typedef logic [dataWidth-1:0] wordT;

    localparam wordT resetPc = 32'h0000_0000;
    localparam wordT overflowVector = 32'h0000_0100;
    localparam wordT illegalVector = 32'h0000_0180;

    typedef enum logic [3:0] {
        FETCH, FETCH_WAIT, DECODE, EXECUTE, ALU_WB, SLT_WB, MEM_READ, MEM_WAIT,
        LOAD_WB, MEM_STORE, BRANCH, EXC_OVERFLOW, EXC_ILLEGAL
    } cpuState;

    typedef enum logic [5:0] {
        R_FORMAT = 6'h00,
        J        = 6'h02,
        BEQ      = 6'h04,
        BNE      = 6'h05,
        ADDI     = 6'h08,
        ADDIU    = 6'h09,
        SLTI     = 6'h0a,
        LW       = 6'h23,
        SW       = 6'h2b
    } opcodeT;

    // funct field of R_FORMAT
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_SLT = 6'h2a
    } functT;

    typedef enum logic [2:0] {ALU_PASS_A, ALU_ADD, ALU_SUB, ALU_AND, ALU_COMPARE} aluOpT;

    typedef enum logic {SRCA_PC, SRCA_REG} aluSrcASel;
    typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM, SRCB_IMM_SHIFT} aluSrcBSel;
    typedef enum logic [2:0] {
        PC_ALU_RESULT, PC_ALU_OUT, PC_JUMP, PC_OVERFLOW_VEC, PC_ILLEGAL_VEC
    } pcSourceSel;
    typedef enum logic {ADDR_PC, ADDR_ALU_OUT} memAddrSel;
    typedef enum logic {DST_RT, DST_RD} regDstSel;
    typedef enum logic [1:0] {WB_ALU_OUT, WB_LOAD, WB_LESS_THAN} wbSel;

    typedef struct packed {
        opcodeT opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        functT funct;
        logic [immWidth-1:0] imm;
        logic [jumpWidth-1:0] jumpIndex;
    } instrFields;

    typedef struct packed {
        logic pcWrite;
        logic irWrite;
        logic mdrWrite;
        logic abWrite;
        logic regWrite;
        logic aluOutWrite;
        logic memWrite;
        aluOpT aluOp;
        aluSrcASel aluSrcA;
        aluSrcBSel aluSrcB;
        pcSourceSel pcSource;
        memAddrSel memAddrSrc;
        regDstSel regDst;
        wbSel wbSource;
    } ctrlSignals;

    typedef struct packed {
        logic zero;
        logic overflow;   // registered with the result
        logic lessThan;
    } aluFlags;

endpackage

/* filelist.f */
common/mipsPkg.sv
rtl/controlUnit.sv
rtl/pcUnit.sv
rtl/memoryPort.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/multicycleCpu.sv
testbench/cpuTb.sv

/* rtl/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit import mipsPkg::*; (
    input  logic       clk,
    input  ctrlSignals ctrl,
    input  wordT       pc,
    input  wordT       regA,
    input  wordT       regB,
    input  instrFields instr,
    output wordT       aluResult,
    output wordT       aluOut,
    output aluFlags    flags
);

    localparam int msb = dataWidth - 1;

    wordT signImm;
    wordT srcA;
    wordT srcB;
    wordT sum;
    wordT diff;
    logic addOverflow;
    logic subOverflow;
    logic resultOverflow;
    logic overflowReg;

    assign signImm = {{(dataWidth-immWidth){instr.imm[immWidth-1]}}, instr.imm};

    assign srcA = (ctrl.aluSrcA == SRCA_PC) ? pc : regA;

    always_comb begin
        case (ctrl.aluSrcB)
            SRCB_FOUR:      srcB = 32'd4;
            SRCB_IMM:       srcB = signImm;
            SRCB_IMM_SHIFT: srcB = {signImm[msb-2:0], 2'b00};   // word offset
            default:        srcB = regB;
        endcase
    end

    assign sum = srcA + srcB;
    assign diff = srcA - srcB;
    // signed overflow when the sign of the result is wrong
    assign addOverflow = (srcA[msb] == srcB[msb]) && (sum[msb] != srcA[msb]);
    assign subOverflow = (srcA[msb] != srcB[msb]) && (diff[msb] != srcA[msb]);

    always_comb begin
        resultOverflow = 1'b0;
        case (ctrl.aluOp)
            ALU_ADD: begin
                aluResult = sum;
                resultOverflow = addOverflow;
            end
            ALU_SUB: begin
                aluResult = diff;
                resultOverflow = subOverflow;
            end
            ALU_AND:     aluResult = srcA & srcB;
            ALU_COMPARE: aluResult = diff;   // zero means equal
            default:     aluResult = srcA;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.aluOutWrite) begin
            aluOut <= aluResult;
            overflowReg <= resultOverflow;
        end
    end

    always_comb begin
        flags.zero = (aluResult == '0);
        flags.overflow = overflowReg;
        flags.lessThan = ($signed(srcA) < $signed(srcB));
    end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit import mipsPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  instrFields instr,
    input  aluFlags    flags,
    output ctrlSignals ctrl
);

    cpuState state;
    cpuState nextState;
    logic isRType;
    logic overflowTrap;

    assign isRType = (instr.opcode == R_FORMAT);

    // only ADD, SUB and ADDI trap, ADDIU wraps silently
    assign overflowTrap = flags.overflow &&
        ((instr.opcode == ADDI) ||
         (isRType && (instr.funct == FN_ADD || instr.funct == FN_SUB)));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = FETCH;

        ctrl.pcWrite = 1'b0;
        ctrl.irWrite = 1'b0;
        ctrl.mdrWrite = 1'b0;
        ctrl.abWrite = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.aluOutWrite = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.aluOp = ALU_PASS_A;
        ctrl.aluSrcA = SRCA_PC;
        ctrl.aluSrcB = SRCB_REG;
        ctrl.pcSource = PC_ALU_RESULT;
        ctrl.memAddrSrc = ADDR_PC;
        ctrl.regDst = DST_RT;
        ctrl.wbSource = WB_ALU_OUT;

        case (state)
            FETCH: begin
                nextState = FETCH_WAIT;   // memory sees pc this cycle
            end
            FETCH_WAIT: begin
                nextState = DECODE;
                ctrl.irWrite = 1'b1;
                ctrl.aluSrcB = SRCB_FOUR;
                ctrl.aluOp = ALU_ADD;
                ctrl.pcWrite = 1'b1;
            end
            DECODE: begin
                nextState = EXECUTE;
                ctrl.abWrite = 1'b1;
                ctrl.aluSrcB = SRCB_IMM_SHIFT;   // branch target
                ctrl.aluOp = ALU_ADD;
                ctrl.aluOutWrite = 1'b1;
            end
            EXECUTE: begin
                nextState = EXC_ILLEGAL;
                ctrl.aluSrcA = SRCA_REG;
                case (instr.opcode)
                    R_FORMAT: begin
                        case (instr.funct)
                            FN_ADD, FN_SUB, FN_AND: begin
                                nextState = ALU_WB;
                                ctrl.aluOutWrite = 1'b1;
                                ctrl.aluOp = (instr.funct == FN_ADD) ? ALU_ADD :
                                             (instr.funct == FN_SUB) ? ALU_SUB : ALU_AND;
                            end
                            FN_SLT: begin
                                nextState = SLT_WB;
                                ctrl.aluOp = ALU_COMPARE;
                            end
                            default: nextState = EXC_ILLEGAL;
                        endcase
                    end
                    ADDI, ADDIU: begin
                        nextState = ALU_WB;
                        ctrl.aluSrcB = SRCB_IMM;
                        ctrl.aluOp = ALU_ADD;
                        ctrl.aluOutWrite = 1'b1;
                    end
                    SLTI: begin
                        nextState = SLT_WB;
                        ctrl.aluSrcB = SRCB_IMM;
                        ctrl.aluOp = ALU_COMPARE;
                    end
                    LW, SW: begin
                        nextState = (instr.opcode == LW) ? MEM_READ : MEM_STORE;
                        ctrl.aluSrcB = SRCB_IMM;   // effective address
                        ctrl.aluOp = ALU_ADD;
                        ctrl.aluOutWrite = 1'b1;
                    end
                    BEQ, BNE: begin
                        nextState = BRANCH;
                        ctrl.aluOp = ALU_COMPARE;
                    end
                    J: begin
                        nextState = FETCH;
                        ctrl.pcSource = PC_JUMP;
                        ctrl.pcWrite = 1'b1;
                    end
                    default: nextState = EXC_ILLEGAL;
                endcase
            end
            ALU_WB: begin
                if (overflowTrap) begin
                    nextState = EXC_OVERFLOW;   // write suppressed
                end else begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst = isRType ? DST_RD : DST_RT;
                end
            end
            SLT_WB: begin
                // operands held so lessThan stays valid
                ctrl.aluSrcA = SRCA_REG;
                ctrl.aluSrcB = isRType ? SRCB_REG : SRCB_IMM;
                ctrl.aluOp = ALU_COMPARE;
                ctrl.regWrite = 1'b1;
                ctrl.regDst = isRType ? DST_RD : DST_RT;
                ctrl.wbSource = WB_LESS_THAN;
            end
            MEM_READ: begin
                nextState = MEM_WAIT;
                ctrl.memAddrSrc = ADDR_ALU_OUT;
            end
            MEM_WAIT: begin
                nextState = LOAD_WB;
                ctrl.mdrWrite = 1'b1;
            end
            LOAD_WB: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSource = WB_LOAD;
            end
            MEM_STORE: begin
                ctrl.memAddrSrc = ADDR_ALU_OUT;
                ctrl.memWrite = 1'b1;
            end
            BRANCH: begin
                ctrl.aluSrcA = SRCA_REG;
                ctrl.aluOp = ALU_COMPARE;
                ctrl.pcSource = PC_ALU_OUT;
                ctrl.pcWrite = (instr.opcode == BEQ) ? flags.zero : !flags.zero;
            end
            EXC_OVERFLOW: begin
                ctrl.pcSource = PC_OVERFLOW_VEC;
                ctrl.pcWrite = 1'b1;
            end
            EXC_ILLEGAL: begin
                ctrl.pcSource = PC_ILLEGAL_VEC;
                ctrl.pcWrite = 1'b1;
            end
            default: nextState = FETCH;
        endcase
    end

endmodule

/* rtl/memoryPort.sv */
`timescale 1ns/10ps

module memoryPort import mipsPkg::*; (
    input  logic       clk,
    input  ctrlSignals ctrl,
    input  wordT       pc,
    input  wordT       aluOut,
    input  wordT       regB,
    input  wordT       memReadData,
    output wordT       memAddr,
    output wordT       memWriteData,
    output logic       memWrite,
    output instrFields instr,
    output wordT       loadData
);

    wordT ir;
    wordT mdr;

    assign memAddr = (ctrl.memAddrSrc == ADDR_PC) ? pc : aluOut;
    assign memWriteData = regB;   // SW stores rt
    assign memWrite = ctrl.memWrite;
    assign loadData = mdr;

    // read data is one cycle behind the address
    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            ir <= memReadData;
        end
        if (ctrl.mdrWrite) begin
            mdr <= memReadData;
        end
    end

    always_comb begin
        instr.opcode = opcodeT'(ir[31:26]);
        instr.rs = ir[25:21];
        instr.rt = ir[20:16];
        instr.rd = ir[15:11];
        instr.funct = functT'(ir[5:0]);
        instr.imm = ir[immWidth-1:0];
        instr.jumpIndex = ir[jumpWidth-1:0];
    end

endmodule

/* rtl/multicycleCpu.sv */
`timescale 1ns/10ps

module multicycleCpu import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    output wordT memAddr,
    output wordT memWriteData,
    output logic memWrite,
    input  wordT memReadData
);

    ctrlSignals ctrl;
    instrFields instr;
    aluFlags flags;
    wordT pc;
    wordT aluResult;
    wordT aluOut;
    wordT regA;
    wordT regB;
    wordT loadData;

    controlUnit controlUnit_inst (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    pcUnit pcUnit_inst (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .aluOut    (aluOut),
        .jumpIndex (instr.jumpIndex),
        .pc        (pc)
    );

    memoryPort memoryPort_inst (
        .clk          (clk),
        .ctrl         (ctrl),
        .pc           (pc),
        .aluOut       (aluOut),
        .regB         (regB),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .instr        (instr),
        .loadData     (loadData)
    );

    registerFile registerFile_inst (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .instr    (instr),
        .aluOut   (aluOut),
        .loadData (loadData),
        .lessThan (flags.lessThan),
        .regA     (regA),
        .regB     (regB)
    );

    aluUnit aluUnit_inst (
        .clk       (clk),
        .ctrl      (ctrl),
        .pc        (pc),
        .regA      (regA),
        .regB      (regB),
        .instr     (instr),
        .aluResult (aluResult),
        .aluOut    (aluOut),
        .flags     (flags)
    );

endmodule

/* rtl/pcUnit.sv */
`timescale 1ns/10ps

module pcUnit import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlSignals           ctrl,
    input  wordT                 aluResult,
    input  wordT                 aluOut,
    input  logic [jumpWidth-1:0] jumpIndex,
    output wordT                 pc
);

    wordT nextPc;
    wordT jumpTarget;

    // upper bits come from pc, which already holds pc+4 here
    assign jumpTarget = {pc[dataWidth-1:dataWidth-4], jumpIndex, 2'b00};

    always_comb begin
        case (ctrl.pcSource)
            PC_ALU_RESULT:   nextPc = aluResult;
            PC_ALU_OUT:      nextPc = aluOut;
            PC_JUMP:         nextPc = jumpTarget;
            PC_OVERFLOW_VEC: nextPc = overflowVector;
            PC_ILLEGAL_VEC:  nextPc = illegalVector;
            default:         nextPc = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (ctrl.pcWrite) begin
            pc <= nextPc;
        end
    end

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/10ps

module registerFile import mipsPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ctrlSignals ctrl,
    input  instrFields instr,
    input  wordT       aluOut,
    input  wordT       loadData,
    input  logic       lessThan,
    output wordT       regA,
    output wordT       regB
);

    wordT regs [0:(1 << regAddrWidth)-1];
    logic [regAddrWidth-1:0] writeAddr;
    wordT writeData;
    wordT readA;
    wordT readB;

    assign writeAddr = (ctrl.regDst == DST_RD) ? instr.rd : instr.rt;

    always_comb begin
        case (ctrl.wbSource)
            WB_LOAD:      writeData = loadData;
            WB_LESS_THAN: writeData = {{(dataWidth-1){1'b0}}, lessThan};
            default:      writeData = aluOut;
        endcase
    end

    assign readA = (instr.rs == '0) ? '0 : regs[instr.rs];   // $0 reads zero
    assign readB = (instr.rt == '0) ? '0 : regs[instr.rt];

    always_ff @(posedge clk) begin
        if (ctrl.regWrite && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regA <= '0;
            regB <= '0;
        end else if (ctrl.abWrite) begin
            regA <= readA;
            regB <= readB;
        end
    end

endmodule

/* testbench/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb import mipsPkg::*; ();

    logic clk;
    logic reset;
    wordT memAddr;
    wordT memWriteData;
    logic memWrite;
    wordT memReadData;

    wordT mem [0:255];   // 1 KB, word addressed
    wordT reqAddr;
    wordT reqData;
    logic reqWrite;
    wordT loadPtr;
    wordT expAddr [$];
    wordT expData [$];
    wordT dataWords [0:3];
    integer seed;

    multicycleCpu multicycleCpu_inst (
        .clk          (clk),
        .reset        (reset),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memReadData  (memReadData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // request taken mid cycle, answered 1 ns after the next edge
    always @(negedge clk) begin
        reqAddr = memAddr;
        reqWrite = memWrite;
        reqData = memWriteData;
    end

    always @(posedge clk) begin
        #1;
        if (reqWrite === 1'b1) begin
            mem[reqAddr[9:2]] = reqData;
        end
        memReadData = mem[reqAddr[9:2]];
    end

    task automatic failRun;
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(input wordT actual, input wordT expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s data 0x%h, expected 0x%h",
                     $time, what, actual, expected);
            failRun();
        end
    endtask

    task automatic checkAddr(input wordT actual, input wordT expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s address 0x%h, expected 0x%h",
                     $time, what, actual, expected);
            failRun();
        end
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b",
                     $time, what, actual, expected);
            failRun();
        end
    endtask

    function automatic wordT rTypeWord(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input functT fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT iTypeWord(input opcodeT op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jumpWord(input wordT target);
        return {J, target[27:2]};
    endfunction

    task automatic placeInstr(input wordT word);
        mem[loadPtr[9:2]] = word;
        loadPtr = loadPtr + 4;
    endtask

    task automatic expectStore(input wordT addr, input wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic buildProgram;
        loadPtr = 32'h000;
        placeInstr(iTypeWord(ADDI, 0, 1, 100));
        placeInstr(iTypeWord(ADDI, 0, 2, -37));
        placeInstr(rTypeWord(1, 2, 3, FN_ADD));
        placeInstr(iTypeWord(SW, 0, 3, 16'h300));
        placeInstr(rTypeWord(2, 1, 4, FN_SUB));
        placeInstr(iTypeWord(SW, 0, 4, 16'h304));
        placeInstr(rTypeWord(1, 2, 5, FN_AND));
        placeInstr(iTypeWord(SW, 0, 5, 16'h308));
        placeInstr(rTypeWord(2, 1, 6, FN_SLT));
        placeInstr(iTypeWord(SW, 0, 6, 16'h30c));
        placeInstr(rTypeWord(1, 2, 7, FN_SLT));
        placeInstr(iTypeWord(SW, 0, 7, 16'h310));
        placeInstr(iTypeWord(ADDI, 2, 8, 1000));
        placeInstr(iTypeWord(SW, 0, 8, 16'h314));
        placeInstr(iTypeWord(ADDIU, 1, 9, -200));
        placeInstr(iTypeWord(SW, 0, 9, 16'h318));
        placeInstr(iTypeWord(SLTI, 2, 10, -36));
        placeInstr(iTypeWord(SW, 0, 10, 16'h31c));
        placeInstr(iTypeWord(SLTI, 1, 11, 5));
        placeInstr(iTypeWord(SW, 0, 11, 16'h320));
        placeInstr(iTypeWord(LW, 0, 12, 16'h204));   // 0x050
        placeInstr(iTypeWord(LW, 0, 13, 16'h208));
        placeInstr(rTypeWord(12, 13, 14, FN_ADD));
        placeInstr(iTypeWord(SW, 0, 14, 16'h324));
        placeInstr(iTypeWord(LW, 0, 15, 16'h20c));
        placeInstr(iTypeWord(LW, 0, 16, 16'h210));
        placeInstr(rTypeWord(15, 16, 17, FN_ADD));
        placeInstr(iTypeWord(SW, 0, 17, 16'h328));
        placeInstr(iTypeWord(BEQ, 1, 1, 1));   // 0x070, taken
        placeInstr(iTypeWord(SW, 0, 1, 16'h330));
        placeInstr(iTypeWord(BEQ, 1, 2, 1));   // not taken
        placeInstr(iTypeWord(SW, 0, 3, 16'h334));
        placeInstr(iTypeWord(BNE, 1, 2, 1));   // taken
        placeInstr(iTypeWord(SW, 0, 1, 16'h338));
        placeInstr(iTypeWord(BNE, 1, 1, 1));   // not taken
        placeInstr(iTypeWord(SW, 0, 4, 16'h33c));
        placeInstr(jumpWord(32'h098));         // 0x090
        placeInstr(iTypeWord(SW, 0, 1, 16'h340));
        placeInstr(iTypeWord(SW, 0, 5, 16'h344));
        placeInstr(iTypeWord(LW, 0, 19, 16'h200));   // largest positive word
        placeInstr(iTypeWord(ADDI, 0, 20, 0));       // exception count
        placeInstr(iTypeWord(ADDI, 0, 23, 1));
        placeInstr(iTypeWord(ADDI, 0, 21, 1));
        placeInstr(iTypeWord(ADDI, 0, 24, 16'h55));
        placeInstr(rTypeWord(19, 21, 24, FN_ADD));   // 0x0b0, overflows
        placeInstr(iTypeWord(SW, 0, 24, 16'h348));   // first return point
        placeInstr(iTypeWord(ADDI, 0, 25, 16'h66));
        placeInstr(iTypeWord(ADDI, 19, 25, 1));      // overflows
        placeInstr(iTypeWord(SW, 0, 25, 16'h34c));   // 0x0c0, second return point
        placeInstr(iTypeWord(ADDIU, 19, 26, 1));
        placeInstr(iTypeWord(SW, 0, 26, 16'h350));
        placeInstr(32'hfc00_0000);                   // opcode 0x3f is unassigned

        // overflow handler, count selects the return point
        loadPtr = overflowVector;
        placeInstr(iTypeWord(ADDI, 20, 20, 1));
        placeInstr(iTypeWord(SW, 0, 20, 16'h360));
        placeInstr(iTypeWord(BEQ, 20, 23, -22));     // back to 0x0b4
        placeInstr(jumpWord(32'h0c0));

        loadPtr = illegalVector;
        placeInstr(iTypeWord(ADDI, 0, 27, 16'h1bad));
        placeInstr(iTypeWord(SW, 0, 27, 16'h364));
        placeInstr(jumpWord(illegalVector + 8));     // spin here
    endtask

    task automatic buildExpected;
        int opA;
        int opB;
        wordT maxPos;
        opA = 100;
        opB = -37;
        maxPos = 32'h7fff_ffff;
        expectStore(32'h300, opA + opB);
        expectStore(32'h304, opB - opA);
        expectStore(32'h308, opA & opB);
        expectStore(32'h30c, (opB < opA) ? 1 : 0);
        expectStore(32'h310, (opA < opB) ? 1 : 0);
        expectStore(32'h314, opB + 1000);
        expectStore(32'h318, opA - 200);
        expectStore(32'h31c, (opB < -36) ? 1 : 0);
        expectStore(32'h320, (opA < 5) ? 1 : 0);
        expectStore(32'h324, dataWords[0] + dataWords[1]);
        expectStore(32'h328, dataWords[2] + dataWords[3]);
        expectStore(32'h334, opA + opB);
        expectStore(32'h33c, opB - opA);
        expectStore(32'h344, opA & opB);
        expectStore(32'h360, 1);
        expectStore(32'h348, 32'h55);   // write of the faulting ADD dropped
        expectStore(32'h360, 2);
        expectStore(32'h34c, 32'h66);
        expectStore(32'h350, maxPos + 1);   // ADDIU wraps
        expectStore(32'h364, 32'h1bad);
    endtask

    initial begin
        int i;
        int cycles;
        logic found;
        reset = 1'b1;
        memReadData = '0;
        seed = 32'h5719_7d9b;
        for (i = 0; i < 256; i++) begin
            mem[i] = 32'hdead_0000 | i;
        end
        for (i = 0; i < 4; i++) begin
            dataWords[i] = $random(seed) >>> 1;   // halved, pair sums stay in range
            mem[129 + i] = dataWords[i];
        end
        mem[128] = 32'h7fff_ffff;
        buildProgram();
        buildExpected();

        repeat (16) begin
            @(posedge clk);
            #1;
            checkBit(memWrite, 1'b0, "memWrite during reset");
        end
        reset = 1'b0;
        checkAddr(memAddr, resetPc, "first fetch");
        repeat (4) begin
            @(posedge clk);
            #1;
            checkBit(memWrite, 1'b0, "memWrite after reset");
        end

        for (i = 0; i < expAddr.size(); i++) begin
            cycles = 0;
            found = 1'b0;
            while (!found && cycles < 200) begin
                @(posedge clk);
                #1;
                cycles++;
                found = (memWrite === 1'b1);
            end
            if (!found) begin
                $display("store %0d to address 0x%h never arrived within 200 cycles",
                         i, expAddr[i]);
                failRun();
            end else begin
                checkAddr(memAddr, expAddr[i], $sformatf("store %0d", i));
                checkWord(memWriteData, expData[i], $sformatf("store %0d", i));
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule
